/* rtl/rw_gen_pkg.sv */
package rw_gen_pkg;

// ------------------------------
// Widths
// ------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 16;

// ------------------------------
// FIFO sizing
// ------------------------------
    localparam int FIFO_DEPTH  = 16;
    // Fill level where prog_full rises
    localparam int PROG_THRESH = 8;

// ------------------------------
// Vector types
// ------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [COUNT_W-1:0] count_t;

// ------------------------------
// Job states
// ------------------------------
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP_REQ,
        SETUP_WAIT,
        START,
        BUSY,
        PAUSE,
        DRAIN,
        DONE
    } gen_state_t;

endpackage : rw_gen_pkg

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH  = 32,
    parameter int DEPTH  = 16,
    parameter int THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             push;
    logic             pop;

    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    assign empty     = (fill == '0);
    assign full      = (fill == CNT_W'(DEPTH));
    assign prog_full = (fill >= CNT_W'(THRESH));

    // Pointers, fill level and read strobe
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            dout <= mem[rd_ptr];
        end
    end

    push_while_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator) wr_en |-> !full
    ) else $error("sync_fifo: push while full, word dropped");

endmodule : sync_fifo

/* rtl/rw_gen_control.sv */
`timescale 1ns/1ps

module rw_gen_control (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               descriptor_valid,
    input  logic               config_ready,
    input  logic               config_valid,
    input  rw_gen_pkg::count_t config_count,
    input  logic               config_mode_counter,
    input  logic               item_taken,
    input  logic               request_prog_full,
    input  logic               fifos_empty,
    input  logic               counter_zero,
    output logic               config_request,
    output logic               gen_enable,
    output logic               done
);

    rw_gen_pkg::gen_state_t state;
    rw_gen_pkg::gen_state_t next_state;
    rw_gen_pkg::count_t     job_count;
    rw_gen_pkg::count_t     item_count;
    logic                   mode_counter;
    logic                   desc_pending;
    logic                   job_request;
    logic                   all_taken;

    // A descriptor may wait here until the config source is ready
    assign job_request = (descriptor_valid | desc_pending) & config_ready;
    assign all_taken   = (item_count == job_count);

// ------------------------------
// State register
// ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= rw_gen_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rw_gen_pkg::RESET: next_state = rw_gen_pkg::IDLE;
            rw_gen_pkg::IDLE, rw_gen_pkg::DONE: begin
                if (job_request) begin
                    next_state = rw_gen_pkg::SETUP_REQ;
                end else if (descriptor_valid) begin
                    next_state = rw_gen_pkg::IDLE;
                end
            end
            rw_gen_pkg::SETUP_REQ: next_state = rw_gen_pkg::SETUP_WAIT;
            rw_gen_pkg::SETUP_WAIT: begin
                if (config_valid) begin
                    next_state = rw_gen_pkg::START;
                end
            end
            rw_gen_pkg::START: next_state = rw_gen_pkg::BUSY;
            rw_gen_pkg::BUSY: begin
                if (all_taken) begin
                    next_state = rw_gen_pkg::DRAIN;
                end else if (request_prog_full) begin
                    next_state = rw_gen_pkg::PAUSE;
                end
            end
            rw_gen_pkg::PAUSE: begin
                if (!request_prog_full) begin
                    next_state = rw_gen_pkg::BUSY;
                end
            end
            rw_gen_pkg::DRAIN: begin
                // Counter mode also waits for every response
                if (fifos_empty && (counter_zero || !mode_counter)) begin
                    next_state = rw_gen_pkg::DONE;
                end
            end
            default: next_state = rw_gen_pkg::RESET;
        endcase
    end

// ------------------------------
// Job bookkeeping
// ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            desc_pending <= 1'b0;
            job_count    <= '0;
            mode_counter <= 1'b0;
            item_count   <= '0;
        end else begin
            if (next_state == rw_gen_pkg::SETUP_REQ) begin
                desc_pending <= 1'b0;
            end else if (descriptor_valid) begin
                desc_pending <= 1'b1;
            end
            if (state == rw_gen_pkg::SETUP_WAIT && config_valid) begin
                job_count    <= config_count;
                mode_counter <= config_mode_counter;
            end
            if (state == rw_gen_pkg::START) begin
                item_count <= '0;
            end else if (item_taken) begin
                item_count <= item_count + 1'b1;
            end
        end
    end

    assign config_request = (state == rw_gen_pkg::SETUP_REQ);
    assign gen_enable     = (state == rw_gen_pkg::BUSY) && !all_taken;
    assign done           = (state == rw_gen_pkg::DONE);

    config_only_when_asked: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        config_valid |-> state == rw_gen_pkg::SETUP_WAIT
    ) else $error("rw_gen_control: config_valid outside SETUP_WAIT");

endmodule : rw_gen_control

/* rtl/rw_gen_kernel.sv */
`timescale 1ns/1ps

module rw_gen_kernel (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              clear,
    input  logic              item_valid,
    input  rw_gen_pkg::data_t item_data,
    input  rw_gen_pkg::addr_t base_address,
    input  rw_gen_pkg::addr_t stride,
    input  logic              write_mode,
    output logic              request_valid,
    output rw_gen_pkg::addr_t request_address,
    output rw_gen_pkg::data_t request_data,
    output logic              request_write,
    output logic              busy
);

    rw_gen_pkg::count_t index;
    rw_gen_pkg::addr_t  offset;

    // Stage one: index of the item now on the FIFO output
    always_ff @(posedge ap_clk) begin
        if (areset_generator || clear) begin
            index <= '0;
        end else if (item_valid) begin
            index <= index + 1'b1;
        end
    end

    assign offset = stride * rw_gen_pkg::addr_t'(index);

    // Stage two: full address, data select and push strobe
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= item_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_address <= base_address + offset;
        request_data    <= write_mode ? item_data : '0;
        request_write   <= write_mode;
    end

    assign busy = item_valid | request_valid;

endmodule : rw_gen_kernel

/* rtl/rw_gen_response_path.sv */
`timescale 1ns/1ps

module rw_gen_response_path (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              request_sent,
    input  logic              memory_in_valid,
    input  rw_gen_pkg::addr_t memory_in_address,
    input  rw_gen_pkg::data_t memory_in_data,
    input  logic              engine_out_ready,
    output logic              engine_out_valid,
    output rw_gen_pkg::addr_t engine_out_address,
    output rw_gen_pkg::data_t engine_out_data,
    output logic              memory_in_ready,
    output logic              counter_zero
);

    rw_gen_pkg::count_t outstanding;

// ------------------------------
// Response forwarding
// ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            memory_in_ready  <= 1'b0;
            engine_out_valid <= 1'b0;
        end else begin
            memory_in_ready  <= engine_out_ready;
            engine_out_valid <= memory_in_valid & memory_in_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        engine_out_address <= memory_in_address;
        engine_out_data    <= memory_in_data;
    end

// ------------------------------
// Outstanding requests
// ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            case ({request_sent, engine_out_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign counter_zero = (outstanding == '0);

    // Memory must not answer more requests than were sent
    no_counter_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (engine_out_valid && !request_sent) |-> !counter_zero
    ) else $error("rw_gen_response_path: response without outstanding request");

endmodule : rw_gen_response_path

/* rtl/engine_read_write_generator.sv */
`timescale 1ns/1ps

module engine_read_write_generator (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               descriptor_valid,
    input  logic               config_ready,
    output logic               config_request,
    input  logic               config_valid,
    input  rw_gen_pkg::addr_t  config_base_address,
    input  rw_gen_pkg::addr_t  config_stride,
    input  rw_gen_pkg::count_t config_count,
    input  logic               config_write_mode,
    input  logic               config_mode_counter,
    input  logic               engine_in_valid,
    input  rw_gen_pkg::data_t  engine_in_data,
    output logic               engine_in_ready,
    input  logic               memory_out_ready,
    output logic               memory_out_valid,
    output rw_gen_pkg::addr_t  memory_out_address,
    output rw_gen_pkg::data_t  memory_out_data,
    output logic               memory_out_write,
    input  logic               memory_in_valid,
    input  rw_gen_pkg::addr_t  memory_in_address,
    input  rw_gen_pkg::data_t  memory_in_data,
    output logic               memory_in_ready,
    input  logic               engine_out_ready,
    output logic               engine_out_valid,
    output rw_gen_pkg::addr_t  engine_out_address,
    output rw_gen_pkg::data_t  engine_out_data,
    output logic               done
);

    localparam int REQ_W = rw_gen_pkg::ADDR_W + rw_gen_pkg::DATA_W + 1;

    rw_gen_pkg::addr_t base_address;
    rw_gen_pkg::addr_t stride;
    logic              write_mode;

    logic              gen_enable;
    logic              in_pop;
    logic              in_empty;
    logic              in_prog_full;
    logic              item_valid;
    rw_gen_pkg::data_t item_data;

    logic              kernel_valid;
    rw_gen_pkg::addr_t kernel_address;
    rw_gen_pkg::data_t kernel_data;
    logic              kernel_write;
    logic              kernel_busy;

    logic              req_empty;
    logic              req_prog_full;
    logic [REQ_W-1:0]  req_dout;
    logic              fifos_empty;
    logic              counter_zero;

    // Job configuration for the kernel
    always_ff @(posedge ap_clk) begin
        if (config_valid) begin
            base_address <= config_base_address;
            stride       <= config_stride;
            write_mode   <= config_write_mode;
        end
    end

// ------------------------------
// Engine input FIFO
// ------------------------------
    assign in_pop          = ~in_empty & gen_enable & ~req_prog_full;
    assign engine_in_ready = ~in_prog_full;

    sync_fifo #(
        .WIDTH (rw_gen_pkg::DATA_W),
        .DEPTH (rw_gen_pkg::FIFO_DEPTH),
        .THRESH(rw_gen_pkg::PROG_THRESH)
    ) u_in_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (engine_in_valid),
        .din             (engine_in_data),
        .rd_en           (in_pop),
        .dout            (item_data),
        .valid           (item_valid),
        .empty           (in_empty),
        .full            (),
        .prog_full       (in_prog_full)
    );

    rw_gen_kernel u_kernel (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .clear           (config_request),
        .item_valid      (item_valid),
        .item_data       (item_data),
        .base_address    (base_address),
        .stride          (stride),
        .write_mode      (write_mode),
        .request_valid   (kernel_valid),
        .request_address (kernel_address),
        .request_data    (kernel_data),
        .request_write   (kernel_write),
        .busy            (kernel_busy)
    );

// ------------------------------
// Memory request FIFO
// ------------------------------
    sync_fifo #(
        .WIDTH (REQ_W),
        .DEPTH (rw_gen_pkg::FIFO_DEPTH),
        .THRESH(rw_gen_pkg::PROG_THRESH)
    ) u_req_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .wr_en           (kernel_valid),
        .din             ({kernel_address, kernel_data, kernel_write}),
        .rd_en           (memory_out_ready),
        .dout            (req_dout),
        .valid           (memory_out_valid),
        .empty           (req_empty),
        .full            (),
        .prog_full       (req_prog_full)
    );

    assign {memory_out_address, memory_out_data, memory_out_write} = req_dout;

    // A request leaving the FIFO still counts until it shows on the port
    assign fifos_empty = in_empty & req_empty & ~kernel_busy & ~memory_out_valid;

    rw_gen_control u_control (
        .ap_clk             (ap_clk),
        .areset_generator   (areset_generator),
        .descriptor_valid   (descriptor_valid),
        .config_ready       (config_ready),
        .config_valid       (config_valid),
        .config_count       (config_count),
        .config_mode_counter(config_mode_counter),
        .item_taken         (in_pop),
        .request_prog_full  (req_prog_full),
        .fifos_empty        (fifos_empty),
        .counter_zero       (counter_zero),
        .config_request     (config_request),
        .gen_enable         (gen_enable),
        .done               (done)
    );

    rw_gen_response_path u_response (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .request_sent      (memory_out_valid),
        .memory_in_valid   (memory_in_valid),
        .memory_in_address (memory_in_address),
        .memory_in_data    (memory_in_data),
        .engine_out_ready  (engine_out_ready),
        .engine_out_valid  (engine_out_valid),
        .engine_out_address(engine_out_address),
        .engine_out_data   (engine_out_data),
        .memory_in_ready   (memory_in_ready),
        .counter_zero      (counter_zero)
    );

endmodule : engine_read_write_generator

/* bench/tb_engine_read_write_generator.sv */
`timescale 1ns/1ps

module tb_engine_read_write_generator;

    localparam int    CFG_TIMEOUT = 50;
    localparam int    JOB_TIMEOUT = 2000;
    localparam string STIM_FILE   = "bench/rw_gen_stim.txt";

    logic               ap_clk;
    logic               areset_generator;
    logic               descriptor_valid;
    logic               config_ready;
    logic               config_request;
    logic               config_valid;
    rw_gen_pkg::addr_t  config_base_address;
    rw_gen_pkg::addr_t  config_stride;
    rw_gen_pkg::count_t config_count;
    logic               config_write_mode;
    logic               config_mode_counter;
    logic               engine_in_valid;
    rw_gen_pkg::data_t  engine_in_data;
    logic               engine_in_ready;
    logic               memory_out_ready;
    logic               memory_out_valid;
    rw_gen_pkg::addr_t  memory_out_address;
    rw_gen_pkg::data_t  memory_out_data;
    logic               memory_out_write;
    logic               memory_in_valid;
    rw_gen_pkg::addr_t  memory_in_address;
    rw_gen_pkg::data_t  memory_in_data;
    logic               memory_in_ready;
    logic               engine_out_ready;
    logic               engine_out_valid;
    rw_gen_pkg::addr_t  engine_out_address;
    rw_gen_pkg::data_t  engine_out_data;
    logic               done;

    // Job record from the stim file
    logic [31:0] j_base;
    logic [31:0] j_stride;
    logic [31:0] j_count;
    logic [31:0] j_wmode;
    logic [31:0] j_cmode;
    logic [31:0] j_hold;
    logic [31:0] j_first;
    logic [31:0] j_step;
    logic [31:0] j_last_addr;
    logic [31:0] j_last_data;

    int                seed;
    int                fd;
    int                error_count;
    int                check_count;
    int                job_errors;
    int                tests_run;
    bit                timeout_hit;
    int                rx_count;
    int                fwd_count;
    int                pushed;
    int                cycle_no;
    int                resp_wait;
    bit                resp_sent;
    bit                responses_on;
    bit                ready_dropped;
    rw_gen_pkg::addr_t sent_addr;
    rw_gen_pkg::addr_t last_addr;
    rw_gen_pkg::data_t last_data;
    rw_gen_pkg::addr_t pend_addr[$];

    engine_read_write_generator uut (.*);

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

// ------------------------------
// Helpers
// ------------------------------
    // Read data returned by the memory model
    function automatic rw_gen_pkg::data_t response_word(input rw_gen_pkg::addr_t addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            job_errors++;
            $display("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0d ns: timed out waiting for %s", $time, what);
        error_count++;
        timeout_hit = 1'b1;
    endtask

    task automatic read_record(output bit found);
        string line;
        int    fields;
        found = 1'b0;
        while (!found && $fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", j_base, j_stride,
                                 j_count, j_wmode, j_cmode, j_hold, j_first, j_step,
                                 j_last_addr, j_last_data);
                if (fields == 10) begin
                    found = 1'b1;
                end else begin
                    $display("ERROR: malformed stimulus line: %s", line);
                    error_count++;
                end
            end
        end
    endtask

    // One clock: sample outputs, then drive inputs for the next edge
    task automatic cycle_step();
        rw_gen_pkg::addr_t exp_addr;
        rw_gen_pkg::data_t exp_data;
        @(negedge ap_clk);
        cycle_no++;
        if (memory_out_valid) begin
            exp_addr = j_base + j_stride * 32'(rx_count);
            exp_data = j_wmode[0] ? j_first + j_step * 32'(rx_count) : 32'h0;
            if (rx_count >= int'(j_count)) begin
                $display("ERROR at %0d ns: request beyond the job's item count", $time);
                error_count++;
                job_errors++;
            end else begin
                check_value(memory_out_address, exp_addr, "request address");
                check_value(memory_out_data, exp_data, "request data");
                check_value(32'(memory_out_write), 32'(j_wmode[0]), "request write flag");
            end
            last_addr = memory_out_address;
            last_data = memory_out_data;
            pend_addr.push_back(memory_out_address);
            rx_count++;
        end
        // Forwarded exactly one cycle after memory_in_valid
        check_value(32'(engine_out_valid), 32'(resp_sent), "engine_out_valid");
        if (resp_sent) begin
            check_value(engine_out_address, sent_addr, "response address");
            check_value(engine_out_data, response_word(sent_addr), "response data");
            fwd_count++;
        end
        // Ready toward memory follows engine_out_ready of the last edge
        check_value(32'(memory_in_ready), 32'(engine_out_ready), "memory_in_ready");
        if (!engine_in_ready) begin
            ready_dropped = 1'b1;
        end

        engine_in_valid = 1'b0;
        if (pushed < int'(j_count) && engine_in_ready) begin
            engine_in_valid = 1'b1;
            engine_in_data  = j_first + j_step * 32'(pushed);
            pushed++;
        end
        memory_out_ready = (cycle_no > int'(j_hold));
        // Engine side stalls now and then
        engine_out_ready = (cycle_no % 8 != 5);

        // Memory model with random response delays
        memory_in_valid = 1'b0;
        resp_sent       = 1'b0;
        if (responses_on && pend_addr.size() > 0 && memory_in_ready) begin
            if (resp_wait > 0) begin
                resp_wait--;
            end else begin
                sent_addr         = pend_addr.pop_front();
                memory_in_valid   = 1'b1;
                memory_in_address = sent_addr;
                memory_in_data    = response_word(sent_addr);
                resp_sent         = 1'b1;
                resp_wait         = $unsigned($random(seed)) % 4;
            end
        end
    endtask

// ------------------------------
// Tests
// ------------------------------
    task automatic check_reset_state();
        job_errors = 0;
        check_value(32'(done), 32'h0, "done after reset");
        check_value(32'(config_request), 32'h0, "config_request after reset");
        check_value(32'(memory_out_valid), 32'h0, "memory_out_valid after reset");
        check_value(32'(engine_out_valid), 32'h0, "engine_out_valid after reset");
        check_value(32'(engine_in_ready), 32'h1, "engine_in_ready after reset");
        $display("test reset_state: %0d errors", job_errors);
    endtask

    task automatic run_job(input int job_no);
        int    waited;
        string kind;
        job_errors    = 0;
        rx_count      = 0;
        fwd_count     = 0;
        pushed        = 0;
        ready_dropped = 1'b0;
        last_addr     = '0;
        last_data     = '0;
        responses_on  = j_cmode[0];
        if (job_no > 1) begin
            check_value(32'(done), 32'h1, "done held until next descriptor");
        end

        descriptor_valid = 1'b1;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        waited = 0;
        while (!config_request && waited < CFG_TIMEOUT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!config_request) begin
            report_timeout("config_request");
            return;
        end
        check_value(32'(waited), 32'h0, "cycles from descriptor to config_request");
        check_value(32'(done), 32'h0, "done after new descriptor");
        @(negedge ap_clk);
        check_value(32'(config_request), 32'h0, "config_request one cycle wide");
        config_valid        = 1'b1;
        config_base_address = j_base;
        config_stride       = j_stride;
        config_count        = j_count[15:0];
        config_write_mode   = j_wmode[0];
        config_mode_counter = j_cmode[0];
        @(negedge ap_clk);
        config_valid = 1'b0;

        cycle_no = 0;
        waited   = 0;
        while (!done && waited < JOB_TIMEOUT) begin
            cycle_step();
            waited++;
        end
        if (!done) begin
            report_timeout("done");
            return;
        end
        check_value(32'(rx_count), j_count, "requests seen at done");
        check_value(32'(fwd_count), j_cmode[0] ? j_count : 32'h0, "responses seen at done");

        // Return whatever the memory still owes
        responses_on = 1'b1;
        waited       = 0;
        while (fwd_count < int'(j_count) && waited < JOB_TIMEOUT) begin
            cycle_step();
            waited++;
        end
        if (fwd_count < int'(j_count)) begin
            report_timeout("forwarded responses");
            return;
        end
        repeat (3) cycle_step();
        check_value(32'(done), 32'h1, "done stays high");
        check_value(last_addr, j_last_addr, "last request address");
        check_value(last_data, j_last_data, "last request data");
        // Stall long enough for both FIFOs and the kernel stages to fill up
        if (j_hold >= j_count && j_count >= 32'(2 * rw_gen_pkg::PROG_THRESH + 2)) begin
            check_value(32'(ready_dropped), 32'h1, "engine_in_ready low under back-pressure");
        end
        if (j_wmode[0]) begin
            kind = "write";
        end else begin
            kind = "read";
        end
        $display("test job %0d: %s, counter mode %0d, %0d requests, %0d responses, %0d errors",
                 job_no, kind, j_cmode[0], rx_count, fwd_count, job_errors);
    endtask

    initial begin
        int job_no;
        bit found;
        seed                = 52073;
        error_count         = 0;
        check_count         = 0;
        tests_run           = 0;
        timeout_hit         = 1'b0;
        resp_wait           = 0;
        resp_sent           = 1'b0;
        responses_on        = 1'b0;
        j_count             = '0;
        j_hold              = '0;
        areset_generator    = 1'b1;
        descriptor_valid    = 1'b0;
        config_ready        = 1'b1;
        config_valid        = 1'b0;
        config_base_address = '0;
        config_stride       = '0;
        config_count        = '0;
        config_write_mode   = 1'b0;
        config_mode_counter = 1'b0;
        engine_in_valid     = 1'b0;
        engine_in_data      = '0;
        memory_out_ready    = 1'b1;
        memory_in_valid     = 1'b0;
        memory_in_address   = '0;
        memory_in_data      = '0;
        engine_out_ready    = 1'b1;

        repeat (8) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        @(negedge ap_clk);
        check_reset_state();
        tests_run++;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", STIM_FILE);
            error_count++;
        end else begin
            job_no = 0;
            read_record(found);
            while (found && !timeout_hit) begin
                job_no++;
                run_job(job_no);
                tests_run++;
                read_record(found);
            end
            $fclose(fd);
            if (job_no == 0) begin
                $display("ERROR: no job records in stimulus file");
                error_count++;
            end
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_engine_read_write_generator

/* bench/rw_gen_stim.txt */
# Columns (hex): base stride count write counter hold first_data data_step last_addr last_data
# Engine word i is first_data + i * data_step, hold is cycles with memory_out_ready low
#
# Write job, counter mode off
00001000 00000004 0005 1 0 00 cafe0000 00000001 00001010 cafe0004
#
# Read job, done without waiting for responses
00002000 00000008 0004 0 0 00 11110000 00000001 00002018 00000000
#
# Long memory stall, input FIFO fills up
00003000 00000010 0018 1 0 3c 0badf000 00000010 00003170 0badf170
#
# Counter mode, done waits for every response
00004000 00000020 0006 1 1 00 a5a50000 00000100 000040a0 a5a50500
#
# Counter mode read with a short stall
00008000 00000004 000c 0 1 10 00000100 00000001 0000802c 00000000
#
# Back to the first base, indices restart at zero
00001000 0000000c 0003 1 1 00 77770000 00000003 00001018 77770006

/* src.f */
rtl/rw_gen_pkg.sv
rtl/sync_fifo.sv
rtl/rw_gen_control.sv
rtl/rw_gen_kernel.sv
rtl/rw_gen_response_path.sv
rtl/engine_read_write_generator.sv
bench/tb_engine_read_write_generator.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the engine read/write generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_engine_read_write_generator \
    -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Simulation did not report success"
exit 1
